// ==== hdl/dc2_pkg.sv ====
package dc2_pkg;

  // cache geometry
  localparam int NUM_SETS    = 256;
  localparam int NUM_WAYS    = 4;
  localparam int LINE_WORDS  = 8;
  localparam int WRITE_WORDS = 4;

  localparam int SET_BITS  = $clog2(NUM_SETS);
  localparam int TAG_BITS  = 16;
  localparam int WORD_BITS = 32;
  localparam int BEN_BITS  = WORD_BITS / 8;

  typedef logic [SET_BITS-1:0] set_idx_t;
  typedef logic [TAG_BITS-1:0] tag_t;

  // tag in the upper bits, set index below it
  typedef logic [TAG_BITS+SET_BITS-1:0] line_addr_t;

  typedef logic [WORD_BITS-1:0] word_t;
  typedef logic [BEN_BITS-1:0]  ben_t;
  typedef logic [$clog2(LINE_WORDS)-1:0] word_idx_t;

  typedef logic [LINE_WORDS*WORD_BITS-1:0]  line_t;   // word i at bit WORD_BITS*i
  typedef logic [WRITE_WORDS*WORD_BITS-1:0] wdata_t;  // word q goes to begin+q

  typedef logic [$clog2(NUM_WAYS)-1:0] way_idx_t;
  typedef logic [$clog2(NUM_WAYS)-1:0] rank_t;  // 0 is least recent

  typedef logic [TAG_BITS:0] tag_entry_t;  // {valid, tag}

  localparam rank_t RANK_MRU = rank_t'(NUM_WAYS - 1);

endpackage

// ==== hdl/dc2_sdp_ram.sv ====
module dc2_sdp_ram #(
  parameter int WIDTH = 32
) (
  input  logic              clk,
  input  logic              rst,
  input  logic              rd_en,
  input  dc2_pkg::set_idx_t rd_addr,
  output logic [WIDTH-1:0]  rd_data,
  input  logic              wr_en,
  input  dc2_pkg::set_idx_t wr_addr,
  input  logic [WIDTH-1:0]  wr_data
);

  logic [WIDTH-1:0]  mem [dc2_pkg::NUM_SETS];
  dc2_pkg::set_idx_t addr_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      addr_q <= '0;
    end else if (rd_en) begin
      addr_q <= rd_addr;  // held between lookups
    end
  end

  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_data;
    end
  end

  // read after the address register, so a same-edge write shows through
  assign rd_data = mem[addr_q];

endmodule

// ==== hdl/dc2_word_bank.sv ====
module dc2_word_bank (
  input  logic              clk,
  input  logic              rst,
  input  logic              rd_en,
  input  dc2_pkg::set_idx_t rd_set,
  output dc2_pkg::word_t    rd_data,
  input  logic              wr_en,
  input  dc2_pkg::ben_t     wr_ben,
  input  dc2_pkg::word_t    wr_word
);

  dc2_pkg::set_idx_t set_q;
  dc2_pkg::word_t    merged;

  // same set as the ram's read register
  always_ff @(posedge clk) begin
    if (rst) begin
      set_q <= '0;
    end else if (rd_en) begin
      set_q <= rd_set;
    end
  end

  // byte merge of new data into the old word
  always_comb begin
    for (int b = 0; b < dc2_pkg::BEN_BITS; b++) begin
      if (wr_ben[b]) begin
        merged[8*b +: 8] = wr_word[8*b +: 8];
      end else begin
        merged[8*b +: 8] = rd_data[8*b +: 8];
      end
    end
  end

  dc2_sdp_ram #(
    .WIDTH($bits(dc2_pkg::word_t))
  ) u_ram (
    .clk     (clk),
    .rst     (rst),
    .rd_en   (rd_en),
    .rd_addr (rd_set),
    .rd_data (rd_data),
    .wr_en   (wr_en),
    .wr_addr (set_q),  // old word read last cycle sits here
    .wr_data (merged)
  );

  // a bank write always lands at least one byte
  a_ben_nonzero: assert property (
    @(posedge clk) disable iff (rst)
    wr_en |-> (wr_ben != '0)
  );

endmodule

// ==== hdl/dc2_way.sv ====
module dc2_way #(
  parameter dc2_pkg::way_idx_t WAY = '0
) (
  input  logic                                    clk,
  input  logic                                    rst,
  input  logic                                    init_active,
  input  dc2_pkg::set_idx_t                       init_set,
  input  logic                                    lookup_en,
  input  dc2_pkg::set_idx_t                       lookup_set,
  input  dc2_pkg::tag_t                           stage_tag,
  input  logic                                    stage_write,
  input  logic                                    stage_insert,
  input  logic                                    sel,
  input  dc2_pkg::rank_t                          hit_rank,
  input  logic [dc2_pkg::LINE_WORDS-1:0]          word_en,
  input  dc2_pkg::ben_t [dc2_pkg::LINE_WORDS-1:0] word_ben,
  input  dc2_pkg::line_t                          word_data,
  output logic                                    hit,
  output logic                                    victim,
  output dc2_pkg::rank_t                          rank,
  output dc2_pkg::line_t                          line
);

  dc2_pkg::set_idx_t              set_q;
  dc2_pkg::set_idx_t              wr_set;
  dc2_pkg::tag_entry_t            tag_rd;
  dc2_pkg::tag_entry_t            tag_wr_data;
  logic                           tag_wr_en;
  dc2_pkg::rank_t                 rank_wr_data;
  logic                           rank_wr_en;
  logic [dc2_pkg::LINE_WORDS-1:0] bank_wr;

  always_ff @(posedge clk) begin
    if (rst) begin
      set_q <= '0;
    end else if (lookup_en) begin
      set_q <= lookup_set;
    end
  end

  // sweep owns the write port during init
  assign wr_set = init_active ? init_set : set_q;

  assign hit = tag_rd[dc2_pkg::TAG_BITS] &&
               (tag_rd[dc2_pkg::TAG_BITS-1:0] == stage_tag);

  assign tag_wr_en   = init_active || (stage_insert && sel);
  assign tag_wr_data = init_active ? '0 : {1'b1, stage_tag};

  dc2_sdp_ram #(
    .WIDTH($bits(dc2_pkg::tag_entry_t))
  ) u_tag_ram (
    .clk     (clk),
    .rst     (rst),
    .rd_en   (lookup_en),
    .rd_addr (lookup_set),
    .rd_data (tag_rd),
    .wr_en   (tag_wr_en),
    .wr_addr (wr_set),
    .wr_data (tag_wr_data)
  );

  assign victim = (rank == '0);

  // hit_rank rests at the MRU rank when no way is selected,
  // so nothing decrements outside an update
  assign rank_wr_en = init_active || sel || (rank > hit_rank);

  always_comb begin
    if (init_active) begin
      rank_wr_data = dc2_pkg::rank_t'(WAY);
    end else if (sel) begin
      rank_wr_data = dc2_pkg::RANK_MRU;
    end else begin
      rank_wr_data = rank - 1'b1;  // slide down past the promoted way
    end
  end

  dc2_sdp_ram #(
    .WIDTH($bits(dc2_pkg::rank_t))
  ) u_rank_ram (
    .clk     (clk),
    .rst     (rst),
    .rd_en   (lookup_en),
    .rd_addr (lookup_set),
    .rd_data (rank),
    .wr_en   (rank_wr_en),
    .wr_addr (wr_set),
    .wr_data (rank_wr_data)
  );

  assign bank_wr = word_en & {dc2_pkg::LINE_WORDS{sel && (stage_write || stage_insert)}};

  for (genvar i = 0; i < dc2_pkg::LINE_WORDS; i++) begin : g_bank
    dc2_word_bank u_bank (
      .clk     (clk),
      .rst     (rst),
      .rd_en   (lookup_en),
      .rd_set  (lookup_set),
      .rd_data (line[i*dc2_pkg::WORD_BITS +: dc2_pkg::WORD_BITS]),
      .wr_en   (bank_wr[i]),
      .wr_ben  (word_ben[i]),
      .wr_word (word_data[i*dc2_pkg::WORD_BITS +: dc2_pkg::WORD_BITS])
    );
  end

  // the block hands back this way's own rank when it picks it
  a_sel_rank: assert property (
    @(posedge clk) disable iff (rst || init_active)
    sel |-> (!$isunknown(rank) && (rank == hit_rank))
  );

endmodule

// ==== hdl/dc2_block.sv ====
module dc2_block (
  input  logic                clk,
  input  logic                rst,
  input  logic                read_en,
  input  logic                write_en,
  input  logic                insert,
  input  dc2_pkg::line_addr_t req_addr,
  input  dc2_pkg::word_idx_t  write_begin,
  input  dc2_pkg::word_idx_t  write_end,
  input  dc2_pkg::ben_t       write_first_ben,
  input  dc2_pkg::ben_t       write_last_ben,
  input  dc2_pkg::wdata_t     write_data,
  input  dc2_pkg::line_t      insert_data,
  output logic                init_done,
  output logic                resp_valid,
  output logic                resp_hit,
  output dc2_pkg::way_idx_t   resp_way,
  output dc2_pkg::line_t      resp_data
);

  typedef enum logic {SWEEP, READY} init_state_t;

  init_state_t       init_state;
  dc2_pkg::set_idx_t init_cnt;
  logic              init_active;

  logic                req_any;
  dc2_pkg::word_idx_t  req_span;

  // stage 1
  logic               s1_read;
  logic               s1_write;
  logic               s1_insert;
  dc2_pkg::tag_t      s1_tag;
  dc2_pkg::word_idx_t s1_begin;
  dc2_pkg::word_idx_t s1_end;
  dc2_pkg::ben_t      s1_first_ben;
  dc2_pkg::ben_t      s1_last_ben;
  dc2_pkg::wdata_t    s1_wdata;
  dc2_pkg::line_t     s1_idata;

  logic [dc2_pkg::LINE_WORDS-1:0]          word_en;
  dc2_pkg::ben_t [dc2_pkg::LINE_WORDS-1:0] word_ben;
  dc2_pkg::line_t                          word_data;

  logic [dc2_pkg::NUM_WAYS-1:0] hit_vec;
  logic [dc2_pkg::NUM_WAYS-1:0] victim_vec;
  logic [dc2_pkg::NUM_WAYS-1:0] sel_vec;
  dc2_pkg::rank_t               rank_vec [dc2_pkg::NUM_WAYS];
  dc2_pkg::line_t               line_vec [dc2_pkg::NUM_WAYS];
  dc2_pkg::way_idx_t            sel_way;
  dc2_pkg::rank_t               hit_rank;
  logic                         any_hit;

  // reset-time sweep over all sets
  always_ff @(posedge clk) begin
    if (rst) begin
      init_state <= SWEEP;
      init_cnt   <= '0;
    end else if (init_state == SWEEP) begin
      init_cnt <= init_cnt + 1'b1;
      if (init_cnt == dc2_pkg::set_idx_t'(dc2_pkg::NUM_SETS - 1)) begin
        init_state <= READY;
      end
    end
  end

  assign init_active = (init_state == SWEEP);
  assign init_done   = (init_state == READY);

  assign req_any  = read_en || write_en || insert;
  assign req_span = write_end - write_begin;  // wraps mod line size

  always_ff @(posedge clk) begin
    if (rst) begin
      s1_read   <= 1'b0;
      s1_write  <= 1'b0;
      s1_insert <= 1'b0;
    end else begin
      s1_read   <= read_en;
      s1_write  <= write_en;
      s1_insert <= insert;
    end
  end

  always_ff @(posedge clk) begin
    s1_tag       <= req_addr[dc2_pkg::SET_BITS +: dc2_pkg::TAG_BITS];
    s1_begin     <= write_begin;
    s1_end       <= write_end;
    s1_first_ben <= write_first_ben;
    s1_last_ben  <= write_last_ben;
    s1_wdata     <= write_data;
    s1_idata     <= insert_data;
  end

  // word placement for the stage-1 write or insert
  always_comb begin
    dc2_pkg::word_idx_t span;
    dc2_pkg::word_idx_t off;
    dc2_pkg::word_idx_t pos;
    span = s1_end - s1_begin;
    for (int i = 0; i < dc2_pkg::LINE_WORDS; i++) begin
      pos = dc2_pkg::word_idx_t'(i);
      off = pos - s1_begin;
      if (s1_insert) begin
        word_ben[i] = '1;
        word_en[i]  = 1'b1;
        word_data[i*dc2_pkg::WORD_BITS +: dc2_pkg::WORD_BITS] =
          s1_idata[i*dc2_pkg::WORD_BITS +: dc2_pkg::WORD_BITS];
      end else begin
        if (pos == s1_begin && pos == s1_end) begin
          word_ben[i] = s1_first_ben & s1_last_ben;
        end else if (pos == s1_begin) begin
          word_ben[i] = s1_first_ben;
        end else if (pos == s1_end) begin
          word_ben[i] = s1_last_ben;
        end else begin
          word_ben[i] = '1;
        end
        word_en[i] = (off <= span) && (word_ben[i] != '0);
        word_data[i*dc2_pkg::WORD_BITS +: dc2_pkg::WORD_BITS] =
          s1_wdata[dc2_pkg::WORD_BITS*off[1:0] +: dc2_pkg::WORD_BITS];
      end
    end
  end

  for (genvar w = 0; w < dc2_pkg::NUM_WAYS; w++) begin : g_way
    dc2_way #(
      .WAY(dc2_pkg::way_idx_t'(w))
    ) u_way (
      .clk          (clk),
      .rst          (rst),
      .init_active  (init_active),
      .init_set     (init_cnt),
      .lookup_en    (req_any),
      .lookup_set   (req_addr[dc2_pkg::SET_BITS-1:0]),
      .stage_tag    (s1_tag),
      .stage_write  (s1_write),
      .stage_insert (s1_insert),
      .sel          (sel_vec[w]),
      .hit_rank     (hit_rank),
      .word_en      (word_en),
      .word_ben     (word_ben),
      .word_data    (word_data),
      .hit          (hit_vec[w]),
      .victim       (victim_vec[w]),
      .rank         (rank_vec[w]),
      .line         (line_vec[w])
    );
  end

  assign any_hit = |hit_vec;

  // selected way takes the update
  always_comb begin
    if (s1_insert) begin
      sel_vec = victim_vec;
    end else if (s1_read || s1_write) begin
      sel_vec = hit_vec;
    end else begin
      sel_vec = '0;
    end
    sel_way = '0;
    for (int w = 0; w < dc2_pkg::NUM_WAYS; w++) begin
      if (sel_vec[w]) begin
        sel_way = dc2_pkg::way_idx_t'(w);
      end
    end
    hit_rank = (|sel_vec) ? rank_vec[sel_way] : dc2_pkg::RANK_MRU;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      resp_valid <= 1'b0;
      resp_hit   <= 1'b0;
      resp_way   <= '0;
      resp_data  <= '0;
    end else begin
      resp_valid <= s1_read || s1_write || s1_insert;
      resp_hit   <= s1_insert || ((s1_read || s1_write) && any_hit);
      resp_way   <= sel_way;
      resp_data  <= (s1_read && any_hit) ? line_vec[sel_way] : '0;
    end
  end

  a_one_strobe: assert property (
    @(posedge clk) disable iff (rst)
    $onehot0({read_en, write_en, insert})
  );

  a_req_after_init: assert property (
    @(posedge clk) disable iff (rst)
    req_any |-> init_done
  );

  a_write_span: assert property (
    @(posedge clk) disable iff (rst)
    write_en |-> (req_span < dc2_pkg::WRITE_WORDS)
  );

  // tags stay unique within a set, ranks a permutation
  a_one_hit: assert property (
    @(posedge clk) disable iff (rst)
    (s1_read || s1_write) |-> $onehot0(hit_vec)
  );

  a_one_victim: assert property (
    @(posedge clk) disable iff (rst)
    s1_insert |-> $onehot(victim_vec)
  );

endmodule

// ==== testbench/tb_clock.sv ====
module tb_clock (
  output logic clk
);

  timeunit 1ns;
  timeprecision 100ps;

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;  // 8 ns period
  end

endmodule

// ==== testbench/dc2_block_tb.sv ====
module dc2_block_tb;

  timeunit 1ns;
  timeprecision 100ps;

  typedef struct packed {
    logic              hit;
    dc2_pkg::way_idx_t way;
    dc2_pkg::line_t    data;
  } exp_t;

  logic                clk;
  logic                rst;
  logic                read_en;
  logic                write_en;
  logic                insert;
  dc2_pkg::line_addr_t req_addr;
  dc2_pkg::word_idx_t  write_begin;
  dc2_pkg::word_idx_t  write_end;
  dc2_pkg::ben_t       write_first_ben;
  dc2_pkg::ben_t       write_last_ben;
  dc2_pkg::wdata_t     write_data;
  dc2_pkg::line_t      insert_data;
  logic                init_done;
  logic                resp_valid;
  logic                resp_hit;
  dc2_pkg::way_idx_t   resp_way;
  dc2_pkg::line_t      resp_data;

  // reference model per set and way
  dc2_pkg::tag_t  m_tag   [dc2_pkg::NUM_SETS][dc2_pkg::NUM_WAYS];
  logic           m_valid [dc2_pkg::NUM_SETS][dc2_pkg::NUM_WAYS];
  int             m_rank  [dc2_pkg::NUM_SETS][dc2_pkg::NUM_WAYS];
  dc2_pkg::line_t m_data  [dc2_pkg::NUM_SETS][dc2_pkg::NUM_WAYS];

  exp_t           exp_q[$];
  logic           issued_d1;
  logic           exp_valid;
  logic           exp_hit;
  dc2_pkg::way_idx_t exp_way;
  dc2_pkg::line_t exp_data;
  int             errors = 0;

  tb_clock clk_gen (.clk(clk));

  dc2_block dc2_block_inst (
    .clk             (clk),
    .rst             (rst),
    .read_en         (read_en),
    .write_en        (write_en),
    .insert          (insert),
    .req_addr        (req_addr),
    .write_begin     (write_begin),
    .write_end       (write_end),
    .write_first_ben (write_first_ben),
    .write_last_ben  (write_last_ben),
    .write_data      (write_data),
    .insert_data     (insert_data),
    .init_done       (init_done),
    .resp_valid      (resp_valid),
    .resp_hit        (resp_hit),
    .resp_way        (resp_way),
    .resp_data       (resp_data)
  );

  // expected response trails its strobe by two edges
  always @(posedge clk) begin
    exp_t head;
    if (rst) begin
      issued_d1 <= 1'b0;
      exp_valid <= 1'b0;
      exp_hit   <= 1'b0;
      exp_way   <= '0;
      exp_data  <= '0;
    end else begin
      issued_d1 <= read_en || write_en || insert;
      exp_valid <= issued_d1;
      if (issued_d1) begin
        if (exp_q.size() == 0) begin
          $display("no expected response was queued when one was due");
          errors++;
        end else begin
          head = exp_q.pop_front();
          exp_hit  <= head.hit;
          exp_way  <= head.way;
          exp_data <= head.data;
        end
      end
    end
  end

  a_valid: assert property (@(posedge clk) disable iff (rst) resp_valid == exp_valid)
    else begin
      errors++;
      $display("Error: resp_valid got %h expected %h", $sampled(resp_valid),
               $sampled(exp_valid));
    end

  a_hit: assert property (@(posedge clk) disable iff (rst) exp_valid |-> resp_hit == exp_hit)
    else begin
      errors++;
      $display("Error: resp_hit got %h expected %h", $sampled(resp_hit), $sampled(exp_hit));
    end

  // way only means something on a hit
  a_way: assert property (@(posedge clk) disable iff (rst)
    (exp_valid && exp_hit) |-> resp_way == exp_way)
    else begin
      errors++;
      $display("Error: resp_way got %h expected %h", $sampled(resp_way), $sampled(exp_way));
    end

  a_data: assert property (@(posedge clk) disable iff (rst)
    exp_valid |-> resp_data == exp_data)
    else begin
      errors++;
      $display("Error: resp_data got %h expected %h", $sampled(resp_data),
               $sampled(exp_data));
    end

  function automatic dc2_pkg::line_addr_t make_addr(dc2_pkg::tag_t t, dc2_pkg::set_idx_t s);
    return {t, s};
  endfunction

  function automatic int find_way(dc2_pkg::set_idx_t s, dc2_pkg::tag_t t);
    for (int w = 0; w < dc2_pkg::NUM_WAYS; w++) begin
      if (m_valid[s][w] && m_tag[s][w] == t) begin
        return w;
      end
    end
    return -1;
  endfunction

  // touched way goes most recent and higher ranks slide down
  function automatic void promote(dc2_pkg::set_idx_t s, int w);
    int r;
    r = m_rank[s][w];
    for (int k = 0; k < dc2_pkg::NUM_WAYS; k++) begin
      if (k == w) begin
        m_rank[s][k] = dc2_pkg::NUM_WAYS - 1;
      end else if (m_rank[s][k] > r) begin
        m_rank[s][k]--;
      end
    end
  endfunction

  function automatic dc2_pkg::line_t merge_write(dc2_pkg::line_t old, dc2_pkg::word_idx_t b,
      dc2_pkg::word_idx_t e, dc2_pkg::ben_t fb, dc2_pkg::ben_t lb, dc2_pkg::wdata_t d);
    dc2_pkg::line_t     res;
    dc2_pkg::word_idx_t span;
    dc2_pkg::word_idx_t pos;
    dc2_pkg::ben_t      be;
    res  = old;
    span = e - b;
    for (int q = 0; q <= int'(span); q++) begin
      pos = b + dc2_pkg::word_idx_t'(q);
      if (pos == b && pos == e) be = fb & lb;
      else if (pos == b) be = fb;
      else if (pos == e) be = lb;
      else be = 4'hf;
      for (int k = 0; k < 4; k++) begin
        if (be[k]) res[32*int'(pos) + 8*k +: 8] = d[32*q + 8*k +: 8];
      end
    end
    return res;
  endfunction

  function automatic dc2_pkg::line_t rand_line();
    dc2_pkg::line_t l;
    for (int i = 0; i < dc2_pkg::LINE_WORDS; i++) l[32*i +: 32] = $urandom;
    return l;
  endfunction

  function automatic dc2_pkg::wdata_t rand_wdata();
    dc2_pkg::wdata_t d;
    for (int i = 0; i < dc2_pkg::WRITE_WORDS; i++) d[32*i +: 32] = $urandom;
    return d;
  endfunction

  function automatic dc2_pkg::ben_t rand_ben();
    return dc2_pkg::ben_t'(($urandom % 15) + 1);  // never zero
  endfunction

  task automatic start_cycle();
    @(posedge clk);
    #1;
  endtask

  task automatic do_read(dc2_pkg::line_addr_t a);
    dc2_pkg::set_idx_t s;
    exp_t              x;
    int                w;
    s = a[dc2_pkg::SET_BITS-1:0];
    w = find_way(s, a[dc2_pkg::SET_BITS +: dc2_pkg::TAG_BITS]);
    start_cycle();
    read_en  = 1'b1;
    write_en = 1'b0;
    insert   = 1'b0;
    req_addr = a;
    x.hit  = (w >= 0);
    x.way  = (w >= 0) ? dc2_pkg::way_idx_t'(w) : '0;
    x.data = (w >= 0) ? m_data[s][w] : '0;
    if (w >= 0) promote(s, w);
    exp_q.push_back(x);
  endtask

  task automatic do_write(dc2_pkg::line_addr_t a, dc2_pkg::word_idx_t b, dc2_pkg::word_idx_t e,
      dc2_pkg::ben_t fb, dc2_pkg::ben_t lb, dc2_pkg::wdata_t d);
    dc2_pkg::set_idx_t s;
    exp_t              x;
    int                w;
    s = a[dc2_pkg::SET_BITS-1:0];
    w = find_way(s, a[dc2_pkg::SET_BITS +: dc2_pkg::TAG_BITS]);
    start_cycle();
    read_en         = 1'b0;
    write_en        = 1'b1;
    insert          = 1'b0;
    req_addr        = a;
    write_begin     = b;
    write_end       = e;
    write_first_ben = fb;
    write_last_ben  = lb;
    write_data      = d;
    x.hit  = (w >= 0);
    x.way  = (w >= 0) ? dc2_pkg::way_idx_t'(w) : '0;
    x.data = '0;
    if (w >= 0) begin
      m_data[s][w] = merge_write(m_data[s][w], b, e, fb, lb, d);
      promote(s, w);
    end
    exp_q.push_back(x);
  endtask

  task automatic do_insert(dc2_pkg::line_addr_t a, dc2_pkg::line_t l);
    dc2_pkg::set_idx_t s;
    exp_t              x;
    int                v;
    s = a[dc2_pkg::SET_BITS-1:0];
    v = 0;
    for (int w = 0; w < dc2_pkg::NUM_WAYS; w++) begin
      if (m_rank[s][w] == 0) v = w;  // least recent way
    end
    start_cycle();
    read_en     = 1'b0;
    write_en    = 1'b0;
    insert      = 1'b1;
    req_addr    = a;
    insert_data = l;
    m_valid[s][v] = 1'b1;
    m_tag[s][v]   = a[dc2_pkg::SET_BITS +: dc2_pkg::TAG_BITS];
    m_data[s][v]  = l;
    promote(s, v);
    x.hit  = 1'b1;
    x.way  = dc2_pkg::way_idx_t'(v);
    x.data = '0;
    exp_q.push_back(x);
  endtask

  // idle until every queued response has been checked
  task automatic drain();
    int n;
    start_cycle();
    read_en  = 1'b0;
    write_en = 1'b0;
    insert   = 1'b0;
    n = 0;
    while (exp_q.size() != 0 && n < 20) begin
      @(posedge clk);
      n++;
    end
    if (exp_q.size() != 0) begin
      $display("responses still pending after 20 idle cycles");
      errors++;
    end
    repeat (2) @(posedge clk);
  endtask

  task automatic run_tests();
    dc2_pkg::tag_t      base;
    dc2_pkg::tag_t      ev_tag;
    dc2_pkg::set_idx_t  s0;
    dc2_pkg::word_idx_t b;
    int                 j;
    base   = dc2_pkg::tag_t'($urandom) & 16'hfff0;
    s0     = 8'h3c;
    ev_tag = '0;
    // empty cache misses everywhere
    for (int i = 0; i < 4; i++) do_read(dc2_pkg::line_addr_t'($urandom));
    drain();
    for (int i = 0; i < 4; i++) do_insert(make_addr(base + 16'(i), s0), rand_line());
    drain();
    for (int i = 0; i < 4; i++) do_read(make_addr(base + 16'(i), s0));
    drain();
    // wraps over words 6 7 0 1
    do_write(make_addr(base + 16'd2, s0), 3'd6, 3'd1, 4'b1100, 4'b0011, rand_wdata());
    do_read(make_addr(base + 16'd2, s0));
    do_write(make_addr(base + 16'd9, s0), 3'd2, 3'd4, 4'hf, 4'hf, rand_wdata());  // miss
    do_read(make_addr(base + 16'd9, s0));
    do_read(make_addr(base + 16'd2, s0));
    drain();
    do_read(make_addr(base + 16'd0, s0));
    do_read(make_addr(base + 16'd3, s0));
    for (int w = 0; w < dc2_pkg::NUM_WAYS; w++) begin
      if (m_rank[s0][w] == 0) ev_tag = m_tag[s0][w];
    end
    do_insert(make_addr(base + 16'd4, s0), rand_line());
    do_read(make_addr(ev_tag, s0));
    do_read(make_addr(base + 16'd4, s0));
    drain();
    // back to back requests that never share a set
    for (int i = 0; i < 4; i++) begin
      do_insert(make_addr(base + 16'(5 + i), s0 + 8'(1 + i)), rand_line());
    end
    for (int i = 0; i < 4; i++) begin
      j = (i + 1) % 4;
      b = dc2_pkg::word_idx_t'($urandom);
      do_write(make_addr(base + 16'(5 + j), s0 + 8'(1 + j)), b,
               b + dc2_pkg::word_idx_t'($urandom % 4), rand_ben(), rand_ben(), rand_wdata());
      do_read(make_addr(base + 16'(5 + i), s0 + 8'(1 + i)));
    end
    drain();
  endtask

  initial begin
    int n;
    void'($urandom(12));
    rst             = 1'b1;
    read_en         = 1'b0;
    write_en        = 1'b0;
    insert          = 1'b0;
    req_addr        = '0;
    write_begin     = '0;
    write_end       = '0;
    write_first_ben = '0;
    write_last_ben  = '0;
    write_data      = '0;
    insert_data     = '0;
    // state the sweep leaves behind
    for (int s = 0; s < dc2_pkg::NUM_SETS; s++) begin
      for (int w = 0; w < dc2_pkg::NUM_WAYS; w++) begin
        m_valid[s][w] = 1'b0;
        m_tag[s][w]   = '0;
        m_rank[s][w]  = w;
        m_data[s][w]  = '0;
      end
    end
    repeat (3) @(posedge clk);
    #1;
    rst = 1'b0;
    if (init_done) begin
      $display("init_done was already high right after reset");
      errors++;
    end
    n = 0;
    while (!init_done && n < 300) begin
      @(posedge clk);
      #1;
      n++;
    end
    if (!init_done) begin
      $display("init_done did not rise within 300 cycles of reset");
      errors++;
    end else begin
      run_tests();
    end
    $display("errors: %0d", errors);
    if (errors == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

// ==== flist.f ====
hdl/dc2_pkg.sv
hdl/dc2_sdp_ram.sv
hdl/dc2_word_bank.sv
hdl/dc2_way.sv
hdl/dc2_block.sv
testbench/tb_clock.sv
testbench/dc2_block_tb.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/100ps -Wno-fatal \
  --top-module dc2_block_tb -f flist.f -o dc2_block_sim

out=$(./obj_dir/dc2_block_sim)
echo "$out"

if echo "$out" | grep -q "PASS: all tests"; then
  exit 0
fi
exit 1
